// ==== dv/arcade_tb.sv ====
// self-checking testbench for arcade_core_top, clk_74a only
// waits out three full core reset holds, so runtime is dominated by those
// stimulus from a 32-bit fibonacci lfsr, fixed seed, one step per bit
`timescale 1ns/1ps
`include "arcade_settings.svh"

module arcade_tb;
    import arcade_pkg::*;

    localparam int N_REG_VECTORS = 24;
    localparam int N_PAD_VECTORS = 64;
    localparam int HOLD = `RESET_HOLD_CYCLES;
    // reset, register vectors, two pad phases and three waited holds
    localparam int WATCHDOG_CYCLES = 10 + N_REG_VECTORS * 8
                                   + 2 * (N_PAD_VECTORS + 8)
                                   + 3 * (HOLD + 16) + 200;

    logic         clk_74a;
    logic         temp_reset;
    logic         i_host_reset_n;
    bridge_addr_t i_bridge_addr;
    logic         i_bridge_rd;
    logic         i_bridge_wr;
    bridge_data_t i_bridge_wr_data;
    bridge_data_t i_cmd_rd_data;
    logic         i_dataslot_requestwrite;
    logic         i_dataslot_allcomplete;
    cont_key_t    i_cont1_key;
    cont_key_t    i_cont2_key;
    bridge_data_t o_bridge_rd_data;
    logic         o_core_reset;
    logic         o_download;
    input_byte_t  o_dip_switches;
    logic [1:0]   o_scanlines;
    logic [2:0]   o_video_preset;
    input_byte_t  o_in0;
    input_byte_t  o_in1;
    input_byte_t  o_in2;

    // register model
    bridge_data_t model_dip;
    bridge_data_t model_mode;
    bridge_data_t model_scnl;

    logic [31:0]  lfsr;
    logic         pad_check_on;
    logic         exp_valid;
    logic [23:0]  exp_bytes;
    int           pad_checks;

    arcade_core_top u_dut (.*);

    initial begin
        clk_74a = 1'b0;
        forever #4 clk_74a = ~clk_74a;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // vertical: up in bit 0, down in bit 2
    // horizontal: right in bit 1, left in bit 3
    function automatic stick_t stick_of(input cont_key_t k, input logic vert);
        stick_t s;
        s = 4'b0000;
        if (vert) begin
            s[0] = k[0];
            s[2] = k[1];
        end else begin
            s[1] = k[3];
            s[3] = k[2];
        end
        return s;
    endfunction

    // expected {in2, in1, in0}
    function automatic logic [23:0] pad_bytes(input cont_key_t k1, input cont_key_t k2,
                                              input logic vert);
        input_byte_t b0;
        input_byte_t b1;
        input_byte_t b2;
        b0 = {k1[5], k1[8], k1[14], k1[7], stick_of(k1, vert)};
        b1 = {k2[5], k2[15], k1[15], k2[7], stick_of(k2, vert)};
        b2 = {4'b0000, k1[9], k2[14], k2[4], k1[4]};
        return {b2, b1, b0};
    endfunction

    task automatic check_eq(input string test, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error %s: expected %h, actual %h", test, exp_val, act_val);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped on failure");
    endtask

    task automatic write_reg(input bridge_addr_t addr, input bridge_data_t data);
        @(negedge clk_74a);
        i_bridge_addr    = addr;
        i_bridge_wr      = 1'b1;
        i_bridge_wr_data = data;
        @(negedge clk_74a);
        i_bridge_wr      = 1'b0;
    endtask

    // strobe, then the buffer shows on the mux one edge later
    task automatic read_back(input bridge_addr_t addr, output bridge_data_t data);
        @(negedge clk_74a);
        i_bridge_addr = addr;
        i_bridge_rd   = 1'b1;
        @(negedge clk_74a);
        i_bridge_rd   = 1'b0;
        data = o_bridge_rd_data;
    endtask

    task automatic wait_core_release();
        int cycles;
        cycles = 0;
        while (o_core_reset && cycles < HOLD + 8) begin
            @(negedge clk_74a);
            cycles++;
        end
        assert (!o_core_reset) else report_failure("core reset never released");
    endtask

    // called right after a reset or dip write
    task automatic measure_hold(input string test);
        int rise;
        int held;
        rise = 0;
        held = 0;
        while (!o_core_reset && rise < 2) begin
            @(negedge clk_74a);
            rise++;
        end
        assert (o_core_reset) else report_failure({test, ": core reset did not rise"});
        while (o_core_reset && held < HOLD + 8) begin
            @(negedge clk_74a);
            held++;
        end
        check_eq({test, "_hold_min"}, 1, held >= HOLD);
        check_eq({test, "_hold_max"}, 1, held <= HOLD + 4);
    endtask

    task automatic pad_phase(input logic vert);
        bridge_data_t data;
        data = rand_bits(31);
        data = {data[30:0], vert};
        write_reg(`ADDR_MODE, data);
        model_mode   = data;
        pad_check_on = 1'b1;
        for (int i = 0; i < N_PAD_VECTORS; i++) begin
            i_cont1_key = rand_bits(16);
            i_cont2_key = rand_bits(16);
            @(negedge clk_74a);
        end
        pad_check_on = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // input byte comparison
    //////////////////////////////////////////////////////////////////////

    // capture the expectation when the decoders sample
    always @(posedge clk_74a) begin
        if (pad_check_on) begin
            exp_bytes <= pad_bytes(i_cont1_key, i_cont2_key, model_mode[0]);
            exp_valid <= 1'b1;
        end else begin
            exp_valid <= 1'b0;
        end
    end

    always @(negedge clk_74a) begin
        if (exp_valid) begin
            check_eq("pad_in0", exp_bytes[7:0], o_in0);
            check_eq("pad_in1", exp_bytes[15:8], o_in1);
            check_eq("pad_in2", exp_bytes[23:16], o_in2);
            pad_checks++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_74a);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        bridge_data_t rd;
        bridge_data_t data;
        logic [1:0]   sel;
        lfsr                    = 32'h7da9097c;
        temp_reset              = 1'b1;
        i_host_reset_n          = 1'b1;
        i_bridge_addr           = '0;
        i_bridge_rd             = 1'b0;
        i_bridge_wr             = 1'b0;
        i_bridge_wr_data        = '0;
        i_cmd_rd_data           = '0;
        i_dataslot_requestwrite = 1'b0;
        i_dataslot_allcomplete  = 1'b0;
        i_cont1_key             = '0;
        i_cont2_key             = '0;
        model_dip               = '0;
        model_mode              = '0;
        model_scnl              = '0;
        pad_check_on            = 1'b0;
        exp_valid               = 1'b0;
        exp_bytes               = '0;
        pad_checks              = 0;
        repeat (10) @(negedge clk_74a);
        temp_reset = 1'b0;

        // reset values, buffer still empty
        check_eq("reset_download", 0, o_download);
        check_eq("reset_in", 0, {o_in2, o_in1, o_in0});
        check_eq("reset_core", 1, o_core_reset);
        i_bridge_addr = `ADDR_RESET;
        #1 check_eq("reset_rd_f0", 0, o_bridge_rd_data);
        @(negedge clk_74a);
        i_bridge_addr = `ADDR_DIP;
        #1 check_eq("reset_rd_f1", 0, o_bridge_rd_data);
        @(negedge clk_74a);
        i_bridge_addr = `ADDR_MODE;
        #1 check_eq("reset_rd_f2", 0, o_bridge_rd_data);
        @(negedge clk_74a);
        i_bridge_addr = `ADDR_SCANLINES;
        #1 check_eq("reset_rd_f3", 0, o_bridge_rd_data);
        read_back(`ADDR_RESET, rd);
        check_eq("status_in_hold", 1, rd);
        wait_core_release();

        // core reset stretching
        write_reg(`ADDR_RESET, rand_bits(32));
        measure_hold("reset_cmd");
        read_back(`ADDR_RESET, rd);
        check_eq("status_released", 0, rd);
        data = rand_bits(32);
        write_reg(`ADDR_DIP, data);
        model_dip = data;
        measure_hold("dip_cmd");
        @(negedge clk_74a);
        i_host_reset_n = 1'b0;
        #1 check_eq("host_reset_low", 1, o_core_reset);
        @(negedge clk_74a);
        i_host_reset_n = 1'b1;
        #1 check_eq("host_reset_high", 0, o_core_reset);

        // random register traffic
        for (int i = 0; i < N_REG_VECTORS; i++) begin
            sel  = rand_bits(2);
            data = rand_bits(32);
            if (sel == 2'd0 || sel == 2'd3) begin
                write_reg(`ADDR_MODE, data);
                model_mode = data;
                read_back(`ADDR_MODE, rd);
                check_eq("rd_mode", model_mode, rd);
            end else if (sel == 2'd1) begin
                write_reg(`ADDR_SCANLINES, data);
                model_scnl = data;
                read_back(`ADDR_SCANLINES, rd);
                check_eq("rd_scanlines", model_scnl, rd);
            end else begin
                write_reg(`ADDR_DIP, data);
                model_dip = data;
                read_back(`ADDR_DIP, rd);
                check_eq("rd_dip", model_dip, rd);
            end
            check_eq("dip_out", model_dip[7:0], o_dip_switches);
            check_eq("scanlines_out", model_scnl[1:0], o_scanlines);
            check_eq("preset_out", model_mode[2:0], o_video_preset);
        end
        @(negedge clk_74a);
        i_bridge_addr = 32'h4000_0010;
        i_cmd_rd_data = rand_bits(32);
        #1 check_eq("rd_unmapped", 0, o_bridge_rd_data);
        @(negedge clk_74a);
        data = rand_bits(24);
        i_bridge_addr = {`ADDR_CMD_TOP, data[23:0]};
        i_cmd_rd_data = rand_bits(32);
        #1 check_eq("rd_cmd_window", i_cmd_rd_data, o_bridge_rd_data);

        // gamepads, horizontal then vertical
        pad_phase(1'b0);
        pad_phase(1'b1);
        repeat (3) @(negedge clk_74a);
        #1 check_eq("pad_check_count", 2 * N_PAD_VECTORS, pad_checks);

        // download flag
        @(negedge clk_74a);
        i_dataslot_requestwrite = 1'b1;
        @(negedge clk_74a);
        i_dataslot_requestwrite = 1'b0;
        check_eq("download_rise", 1, o_download);
        i_dataslot_allcomplete = 1'b1;
        @(negedge clk_74a);
        i_dataslot_allcomplete = 1'b0;
        check_eq("download_fall", 0, o_download);
        i_dataslot_requestwrite = 1'b1;
        i_dataslot_allcomplete  = 1'b1;
        @(negedge clk_74a);
        i_dataslot_requestwrite = 1'b0;
        i_dataslot_allcomplete  = 1'b0;
        check_eq("download_both", 1, o_download);
        @(negedge clk_74a);
        check_eq("download_hold", 1, o_download);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/arcade_pkg.sv
hw/pad_if.sv
hw/bridge_config_regs.sv
hw/core_reset_timer.sv
hw/player_pad_decoder.sv
hw/arcade_core_top.sv
dv/arcade_tb.sv

// ==== hw/arcade_core_top.sv ====
// host-facing control logic of the arcade wrapper, clk_74a only
// the byte packing assumes exactly two players
// o_core_reset is high out of temp_reset until the first hold ends
// command handler read data and reset come in as plain inputs
`timescale 1ns/1ps
`include "arcade_settings.svh"

module arcade_core_top (
    input  logic                     clk_74a,
    input  logic                     temp_reset,
    input  logic                     i_host_reset_n,
    // bridge
    input  arcade_pkg::bridge_addr_t i_bridge_addr,
    input  logic                     i_bridge_rd,
    input  logic                     i_bridge_wr,
    input  arcade_pkg::bridge_data_t i_bridge_wr_data,
    input  arcade_pkg::bridge_data_t i_cmd_rd_data,
    // data slots
    input  logic                     i_dataslot_requestwrite,
    input  logic                     i_dataslot_allcomplete,
    // controllers
    input  arcade_pkg::cont_key_t    i_cont1_key,
    input  arcade_pkg::cont_key_t    i_cont2_key,
    // to host and core
    output arcade_pkg::bridge_data_t o_bridge_rd_data,
    output logic                     o_core_reset,
    output logic                     o_download,
    output arcade_pkg::input_byte_t  o_dip_switches,
    output logic [1:0]               o_scanlines,
    output logic [2:0]               o_video_preset,
    // cabinet input ports
    output arcade_pkg::input_byte_t  o_in0,
    output arcade_pkg::input_byte_t  o_in1,
    output arcade_pkg::input_byte_t  o_in2
);
    import arcade_pkg::*;

    logic        reset_pulse;
    input_byte_t mode;
    cont_key_t   keys [`NUM_PLAYERS];

    //////////////////////////////////////////////////////////////////////
    // settings and core reset
    //////////////////////////////////////////////////////////////////////

    bridge_config_regs u_regs (
        .clk_74a                 (clk_74a),
        .temp_reset              (temp_reset),
        .i_bridge_addr           (i_bridge_addr),
        .i_bridge_rd             (i_bridge_rd),
        .i_bridge_wr             (i_bridge_wr),
        .i_bridge_wr_data        (i_bridge_wr_data),
        .i_cmd_rd_data           (i_cmd_rd_data),
        .i_core_reset            (o_core_reset),
        .i_dataslot_requestwrite (i_dataslot_requestwrite),
        .i_dataslot_allcomplete  (i_dataslot_allcomplete),
        .o_bridge_rd_data        (o_bridge_rd_data),
        .o_reset_pulse           (reset_pulse),
        .o_dip_switches          (o_dip_switches),
        .o_mode                  (mode),
        .o_scanlines             (o_scanlines),
        .o_download              (o_download)
    );

    core_reset_timer u_rst (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .i_reset_pulse  (reset_pulse),
        .i_host_reset_n (i_host_reset_n),
        .o_core_reset   (o_core_reset)
    );

    // low mode bits pick the scaler preset
    assign o_video_preset = mode[2:0];

    //////////////////////////////////////////////////////////////////////
    // player decoders
    //////////////////////////////////////////////////////////////////////

    assign keys[0] = i_cont1_key;
    assign keys[1] = i_cont2_key;

    pad_if u_pad [`NUM_PLAYERS] ();

    generate
        for (genvar p = 0; p < `NUM_PLAYERS; p++) begin : g_player
            // mode bit 0 selects vertical cabinet
            player_pad_decoder u_dec (
                .clk_74a    (clk_74a),
                .temp_reset (temp_reset),
                .i_key      (keys[p]),
                .i_vertical (mode[0]),
                .o_pad      (u_pad[p])
            );
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // cabinet input bytes
    //////////////////////////////////////////////////////////////////////

    // player 1 stick and buttons, l1 doubles as service
    assign o_in0 = {u_pad[0].fire_c, u_pad[0].aux_l, u_pad[0].coin,
                    u_pad[0].fire_l, u_pad[0].stick};

    // player 2 stick, both start buttons share this port
    assign o_in1 = {u_pad[1].fire_c, u_pad[1].start, u_pad[0].start,
                    u_pad[1].fire_l, u_pad[1].stick};

    // upper nibble unused by the cabinet
    assign o_in2 = {4'b0000, u_pad[0].aux_r, u_pad[1].coin,
                    u_pad[1].fire_r, u_pad[0].fire_r};

endmodule

// ==== hw/arcade_pkg.sv ====
// shared types for the arcade wrapper control logic
// widths here must agree with the bridge and controller pinout

package arcade_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge bus
    //////////////////////////////////////////////////////////////////////

    // bridge address word
    typedef logic [31:0] bridge_addr_t;
    // bridge read and write data word
    typedef logic [31:0] bridge_data_t;

    //////////////////////////////////////////////////////////////////////
    // controls
    //////////////////////////////////////////////////////////////////////

    // raw key bitmap from one controller
    typedef logic [15:0] cont_key_t;
    // one cabinet input port as seen by the core
    typedef logic [7:0]  input_byte_t;
    // joystick nibble after orientation
    typedef logic [3:0]  stick_t;

    //////////////////////////////////////////////////////////////////////
    // core reset timer
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] reset_count_t;

    // run = core free, hold = core kept in reset
    typedef enum logic {
        RUN  = 1'b0,
        HOLD = 1'b1
    } rst_state_t;

endpackage

// ==== hw/arcade_settings.svh ====
// bridge map, reset hold length and player count for the arcade wrapper
// addresses are full 32-bit matches except the command window,
// which is selected by the upper byte only
`ifndef ARCADE_SETTINGS_SVH
`define ARCADE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// bridge register map
//////////////////////////////////////////////////////////////////////

// core reset command, readback shows live core reset in bit 0
`define ADDR_RESET      32'hF000_0000
// dip switch bank, a write also restarts the core
`define ADDR_DIP        32'hF100_0000
// core mode, bit 0 is cabinet orientation, bits 2:0 video preset
`define ADDR_MODE       32'hF200_0000
// scanline intensity, low two bits used
`define ADDR_SCANLINES  32'hF300_0000
// upper address byte of the command handler window
`define ADDR_CMD_TOP    8'hF8

//////////////////////////////////////////////////////////////////////
// core control
//////////////////////////////////////////////////////////////////////

// core reset hold in clk_74a cycles, must fit reset_count_t
`define RESET_HOLD_CYCLES  8000
`define NUM_PLAYERS        2

`endif

// ==== hw/bridge_config_regs.sv ====
// host settings registers on the bridge, single clock clk_74a
// bridge writes to the reset or dip address must be at least
// two cycles apart, otherwise the reset pulse stretches
// readback needs a read strobe one cycle before the data is used
`timescale 1ns/1ps
`include "arcade_settings.svh"

module bridge_config_regs (
    input  logic                     clk_74a,
    input  logic                     temp_reset,
    input  arcade_pkg::bridge_addr_t i_bridge_addr,
    input  logic                     i_bridge_rd,
    input  logic                     i_bridge_wr,
    input  arcade_pkg::bridge_data_t i_bridge_wr_data,
    input  arcade_pkg::bridge_data_t i_cmd_rd_data,
    input  logic                     i_core_reset,
    input  logic                     i_dataslot_requestwrite,
    input  logic                     i_dataslot_allcomplete,
    output arcade_pkg::bridge_data_t o_bridge_rd_data,
    output logic                     o_reset_pulse,
    output arcade_pkg::input_byte_t  o_dip_switches,
    output arcade_pkg::input_byte_t  o_mode,
    output logic [1:0]               o_scanlines,
    output logic                     o_download
);
    import arcade_pkg::*;

    // full words kept so the host reads back what it wrote
    bridge_data_t dip_reg;
    bridge_data_t mode_reg;
    bridge_data_t scnl_reg;
    bridge_data_t rd_buffer;

    // address hits
    logic hit_reset;
    logic hit_dip;
    logic hit_mode;
    logic hit_scnl;
    logic hit_regs;

    assign hit_reset = (i_bridge_addr == `ADDR_RESET);
    assign hit_dip   = (i_bridge_addr == `ADDR_DIP);
    assign hit_mode  = (i_bridge_addr == `ADDR_MODE);
    assign hit_scnl  = (i_bridge_addr == `ADDR_SCANLINES);
    assign hit_regs  = hit_reset | hit_dip | hit_mode | hit_scnl;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dip_reg       <= '0;
            mode_reg      <= '0;
            scnl_reg      <= '0;
            o_reset_pulse <= 1'b0;
        end else begin
            // one cycle core restart on reset command or new dips
            o_reset_pulse <= i_bridge_wr & (hit_reset | hit_dip);
            if (i_bridge_wr && hit_dip) begin
                dip_reg <= i_bridge_wr_data;
            end
            if (i_bridge_wr && hit_mode) begin
                mode_reg <= i_bridge_wr_data;
            end
            if (i_bridge_wr && hit_scnl) begin
                scnl_reg <= i_bridge_wr_data;
            end
        end
    end

    // only the low bits reach the core
    assign o_dip_switches = dip_reg[7:0];
    assign o_mode         = mode_reg[7:0];
    assign o_scanlines    = scnl_reg[1:0];

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    // buffer loads on the strobe, host picks it up later
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            rd_buffer <= '0;
        end else if (i_bridge_rd && hit_regs) begin
            if (hit_reset) begin
                // live core reset status
                rd_buffer <= {31'b0, i_core_reset};
            end else if (hit_dip) begin
                rd_buffer <= dip_reg;
            end else if (hit_mode) begin
                rd_buffer <= mode_reg;
            end else begin
                rd_buffer <= scnl_reg;
            end
        end
    end

    // read mux follows the address combinationally
    always_comb begin
        if (hit_regs) begin
            o_bridge_rd_data = rd_buffer;
        end else if (i_bridge_addr[31:24] == `ADDR_CMD_TOP) begin
            // command handler window
            o_bridge_rd_data = i_cmd_rd_data;
        end else begin
            o_bridge_rd_data = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // download flag
    //////////////////////////////////////////////////////////////////////

    // request wins over completion
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            o_download <= 1'b0;
        end else if (i_dataslot_requestwrite) begin
            o_download <= 1'b1;
        end else if (i_dataslot_allcomplete) begin
            o_download <= 1'b0;
        end
    end

    // bridge keeps reset and dip writes apart
    a_pulse_single : assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        o_reset_pulse |=> !o_reset_pulse
    );

endmodule

// ==== hw/core_reset_timer.sv ====
// core reset stretcher, output is high right after temp_reset
// a new pulse during a hold restarts the full count
// host reset is used as a level, no synchronizer here
`timescale 1ns/1ps
`include "arcade_settings.svh"

module core_reset_timer (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic i_reset_pulse,
    input  logic i_host_reset_n,
    output logic o_core_reset
);
    import arcade_pkg::*;

    rst_state_t   state;
    reset_count_t count;

    //////////////////////////////////////////////////////////////////////
    // hold fsm with down-counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            // power-up starts in a full hold
            state <= HOLD;
            count <= reset_count_t'(`RESET_HOLD_CYCLES);
        end else if (i_reset_pulse) begin
            state <= HOLD;
            count <= reset_count_t'(`RESET_HOLD_CYCLES);
        end else begin
            case (state)
                HOLD: begin
                    if (count == '0) begin
                        state <= RUN;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    // run, counter idles at zero
                    state <= RUN;
                end
            endcase
        end
    end

    // host reset overrides the fsm
    assign o_core_reset = (state == HOLD) | ~i_host_reset_n;

    // leaving hold only happens from an exhausted count
    a_run_idle : assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        (state == RUN) |-> (count == '0)
    );

endmodule

// ==== hw/pad_if.sv ====
// decoded controls of one player, all registered by the decoder
// every signal is active high
`timescale 1ns/1ps

interface pad_if;
    import arcade_pkg::*;

    // oriented joystick nibble
    stick_t stick;
    // fire buttons left, centre, right
    logic   fire_l;
    logic   fire_c;
    logic   fire_r;
    // cabinet buttons
    logic   coin;
    logic   start;
    // shoulder buttons, extra cabinet functions
    logic   aux_l;
    logic   aux_r;

    // decoder side
    modport source (
        output stick, fire_l, fire_c, fire_r, coin, start, aux_l, aux_r
    );

    // byte packing side
    modport sink (
        input stick, fire_l, fire_c, fire_r, coin, start, aux_l, aux_r
    );

endinterface

// ==== hw/player_pad_decoder.sv ====
// one controller to cabinet controls, one cycle latency
// key bits follow the standard pocket bitmap
// orientation uses the mode bit of the same cycle as the keys
`timescale 1ns/1ps

module player_pad_decoder (
    input  logic                  clk_74a,
    input  logic                  temp_reset,
    input  arcade_pkg::cont_key_t i_key,
    input  logic                  i_vertical,
    pad_if.source                 o_pad
);
    import arcade_pkg::*;

    // dpad fields
    logic   key_up;
    logic   key_down;
    logic   key_left;
    logic   key_right;
    stick_t stick_next;

    assign key_up    = i_key[0];
    assign key_down  = i_key[1];
    assign key_left  = i_key[2];
    assign key_right = i_key[3];

    //////////////////////////////////////////////////////////////////////
    // orientation
    //////////////////////////////////////////////////////////////////////

    // vertical cabinet uses up and down only
    // horizontal uses left and right, one slot up
    always_comb begin
        if (i_vertical) begin
            stick_next = {1'b0, key_down, 1'b0, key_up};
        end else begin
            stick_next = {key_left, 1'b0, key_right, 1'b0};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            o_pad.stick  <= '0;
            o_pad.fire_l <= 1'b0;
            o_pad.fire_c <= 1'b0;
            o_pad.fire_r <= 1'b0;
            o_pad.coin   <= 1'b0;
            o_pad.start  <= 1'b0;
            o_pad.aux_l  <= 1'b0;
            o_pad.aux_r  <= 1'b0;
        end else begin
            o_pad.stick  <= stick_next;
            // a, b, y
            o_pad.fire_r <= i_key[4];
            o_pad.fire_c <= i_key[5];
            o_pad.fire_l <= i_key[7];
            // l1, r1
            o_pad.aux_l  <= i_key[8];
            o_pad.aux_r  <= i_key[9];
            // select, start
            o_pad.coin   <= i_key[14];
            o_pad.start  <= i_key[15];
        end
    end

    // unused slots of last cycle's orientation stay clear
    a_stick_slots : assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        (o_pad.stick & ($past(i_vertical) ? 4'b1010 : 4'b0101)) == 4'b0000
    );

endmodule
